/* Makefile */
SRCS := dsp_mul.f $(wildcard src/*.sv tests/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vtb_dsp_mul: $(SRCS)
	verilator --binary --assert --top-module tb_dsp_mul -f dsp_mul.f

# The log decides pass or fail, the simulator status is ignored.
run: obj_dir/Vtb_dsp_mul
	-obj_dir/Vtb_dsp_mul > sim.log 2>&1
	cat sim.log
	grep -qx "Simulation passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* dsp_mul.f */
src/dsp_pkg.sv
src/booth_recoder.sv
src/booth_row.sv
src/pp_accumulator.sv
src/dsp_mul.sv
tests/tb_clock.sv
tests/tb_dsp_mul.sv

/* src/booth_recoder.sv */
module booth_recoder
   import dsp_pkg::*;
#(
   parameter int DATA_W = 16
) (
   input  logic                          clk,
   input  logic                          arst_n,
   input  mode_t                         mode,
   input  logic [DATA_W-1:0]             a,
   input  logic [DATA_W-1:0]             b,
   output booth_sel_t [DATA_W/2-1:0]     sel,
   output logic [DATA_W/2-1:0][DATA_W:0] mcand,
   output logic [DATA_W-1:0]             corr_lo,
   output logic [DATA_W-1:0]             corr_hi,
   output mode_t                         mode_q
);

   localparam int ROWS    = DATA_W / 2;
   localparam int HALF    = LANE_SPLIT;
   localparam int CUT_ROW = HALF / 2;  // First row of the upper lane.

   logic [DATA_W-1:0] a_q;
   logic [DATA_W-1:0] b_q;
   logic              dual;
   logic              sgn;
   logic [DATA_W:0]   mc_full;
   logic [DATA_W:0]   mc_lo;
   logic [DATA_W:0]   mc_hi;

   // The lanes must meet in the middle of the operands.
   if (DATA_W != 2 * HALF) begin : g_split_chk
      $error("DATA_W must be twice LANE_SPLIT");
   end

   // ====================
   // Operand register
   // ====================

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         mode_q <= MODE_U16;
         a_q    <= '0;
         b_q    <= '0;
      end else begin
         mode_q <= mode;
         a_q    <= a;
         b_q    <= b;
      end
   end

   assign dual = (mode_q == MODE_U8X2) || (mode_q == MODE_S8X2);
   assign sgn  = (mode_q == MODE_S16) || (mode_q == MODE_S8X2);

   // Multiplicand candidates, one bit wider than the operand.
   assign mc_full = {sgn & b_q[DATA_W-1], b_q};
   assign mc_lo   = {{(DATA_W+1-HALF){sgn & b_q[HALF-1]}}, b_q[HALF-1:0]};
   assign mc_hi   = {{(DATA_W+1-HALF){sgn & b_q[DATA_W-1]}}, b_q[DATA_W-1:HALF]};

   // ====================
   // Booth digits
   // ====================

   for (genvar k = 0; k < ROWS; k++) begin : g_row
      logic [BOOTH_DIGIT_W-1:0] win;

      assign win[2:1] = a_q[2*k+1 -: 2];

      if (k == 0) begin : g_first
         assign win[0] = 1'b0;
      end else if (k == CUT_ROW) begin : g_cut
         // Upper lane starts fresh in dual mode.
         assign win[0] = a_q[2*k-1] & ~dual;
      end else begin : g_mid
         assign win[0] = a_q[2*k-1];
      end

      assign sel[k].one = win[1] ^ win[0];
      assign sel[k].two = (win == 3'b011) || (win == 3'b100);
      assign sel[k].neg = win[2] & ~(win[1] & win[0]);

      if (k < CUT_ROW) begin : g_lo_mc
         assign mcand[k] = dual ? mc_lo : mc_full;
      end else begin : g_hi_mc
         assign mcand[k] = dual ? mc_hi : mc_full;
      end
   end

   // Unsigned fix-up. The top window reads the multiplier as signed.
   assign corr_lo = (dual && !sgn && a_q[HALF-1]) ? {{HALF{1'b0}}, b_q[HALF-1:0]} : '0;

   always_comb begin
      if (sgn || !a_q[DATA_W-1]) begin
         corr_hi = '0;
      end else if (dual) begin
         corr_hi = {{HALF{1'b0}}, b_q[DATA_W-1:HALF]};
      end else begin
         corr_hi = b_q;
      end
   end

   a_mode_known : assert property (
      @(posedge clk) disable iff (!arst_n) !$isunknown(mode_q)
   ) else $error("mode_q unknown out of reset");

endmodule

/* src/booth_row.sv */
module booth_row
   import dsp_pkg::*;
#(
   parameter int DATA_W = 16
) (
   input  booth_sel_t        sel,
   input  logic [DATA_W:0]   mcand,
   output logic [DATA_W+1:0] row
);

   logic [DATA_W+1:0] mag;

   // ====================
   // Row select
   // ====================

   // 0, 1x or 2x of the multiplicand.
   always_comb begin
      if (sel.two) begin
         mag = {mcand, 1'b0};
      end else if (sel.one) begin
         mag = {mcand[DATA_W], mcand};  // Keep the sign.
      end else begin
         mag = '0;
      end
   end

   // One's complement here; the +1 is added by the accumulator.
   assign row = sel.neg ? ~mag : mag;

   // The recoder never asks for both magnitudes at once.
   always_comb begin
      assert (!(sel.one && sel.two))
         else $error("booth_row: one and two both set");
   end

endmodule

/* src/dsp_mul.sv */
module dsp_mul
   import dsp_pkg::*;
#(
   parameter int DATA_W = 16
) (
   input  logic                clk,
   input  logic                arst_n,
   input  mode_t               mode,
   input  logic [DATA_W-1:0]   a,
   input  logic [DATA_W-1:0]   b,
   output logic [2*DATA_W-1:0] result
);

   localparam int ROWS = DATA_W / 2;

   booth_sel_t [ROWS-1:0]        sel;
   logic [ROWS-1:0][DATA_W:0]    mcand;
   logic [ROWS-1:0][DATA_W+1:0]  row;
   logic [DATA_W-1:0]            corr_lo;
   logic [DATA_W-1:0]            corr_hi;
   mode_t                        mode_q;

   // ====================
   // Stage 1, recode
   // ====================

   booth_recoder #(.DATA_W(DATA_W)) u_recoder (
      .clk     (clk),
      .arst_n  (arst_n),
      .mode    (mode),
      .a       (a),
      .b       (b),
      .sel     (sel),
      .mcand   (mcand),
      .corr_lo (corr_lo),
      .corr_hi (corr_hi),
      .mode_q  (mode_q)
   );

   for (genvar k = 0; k < ROWS; k++) begin : g_rows
      booth_row #(.DATA_W(DATA_W)) u_row (
         .sel   (sel[k]),
         .mcand (mcand[k]),
         .row   (row[k])
      );
   end

   // ====================
   // Stage 2, sum
   // ====================

   pp_accumulator #(.DATA_W(DATA_W)) u_acc (
      .clk     (clk),
      .arst_n  (arst_n),
      .mode_q  (mode_q),
      .sel     (sel),
      .row     (row),
      .corr_lo (corr_lo),
      .corr_hi (corr_hi),
      .result  (result)
   );

endmodule

/* src/dsp_pkg.sv */
package dsp_pkg;

   // ====================
   // Multiply modes
   // ====================

   // Full width or two packed lanes, unsigned or signed.
   typedef enum logic [1:0] {
      MODE_U16  = 2'd0,
      MODE_S16  = 2'd1,
      MODE_U8X2 = 2'd2,
      MODE_S8X2 = 2'd3
   } mode_t;

   // ====================
   // Booth recoding
   // ====================

   localparam int BOOTH_DIGIT_W = 3;  // Overlapping multiplier window.

   // Row select, zero when the window recodes to 0.
   typedef struct packed {
      logic one;  // Take the multiplicand.
      logic two;  // Take twice the multiplicand.
      logic neg;  // Negate the row.
   } booth_sel_t;

   localparam int LANE_SPLIT = 8;  // Lane cut in dual mode.

endpackage

/* src/pp_accumulator.sv */
module pp_accumulator
   import dsp_pkg::*;
#(
   parameter int DATA_W = 16
) (
   input  logic                            clk,
   input  logic                            arst_n,
   input  mode_t                           mode_q,
   input  booth_sel_t [DATA_W/2-1:0]       sel,
   input  logic [DATA_W/2-1:0][DATA_W+1:0] row,
   input  logic [DATA_W-1:0]               corr_lo,
   input  logic [DATA_W-1:0]               corr_hi,
   output logic [2*DATA_W-1:0]             result
);

   localparam int ROWS  = DATA_W / 2;
   localparam int HALF  = DATA_W / 2;
   localparam int ACC_W = 2 * DATA_W;

   logic                       dual;
   logic [ROWS-1:0][ACC_W-1:0] pp;
   logic [ACC_W-1:0]           lo_sum;
   logic [ACC_W-1:0]           hi_sum;
   logic [ACC_W-1:0]           full_sum;
   logic [DATA_W-1:0]          lo_lane;
   logic [DATA_W-1:0]          hi_lane;
   logic [ACC_W-1:0]           next_result;

   assign dual = (mode_q == MODE_U8X2) || (mode_q == MODE_S8X2);

   // ====================
   // Row completion
   // ====================

   // Sign-extend and finish the two's complement.
   for (genvar k = 0; k < ROWS; k++) begin : g_pp
      assign pp[k] = {{(ACC_W-DATA_W-2){row[k][DATA_W+1]}}, row[k]}
                     + ACC_W'(sel[k].neg);
   end

   // ====================
   // Lane sums
   // ====================

   always_comb begin
      lo_sum = ACC_W'(corr_lo) << HALF;
      hi_sum = ACC_W'(corr_hi) << (dual ? HALF : DATA_W);

      for (int k = 0; k < ROWS / 2; k++) begin
         lo_sum = lo_sum + (pp[k] << (2 * k));
      end

      // Upper lane drops to weight zero in dual mode.
      for (int k = ROWS / 2; k < ROWS; k++) begin
         hi_sum = hi_sum + (pp[k] << (dual ? 2 * k - HALF : 2 * k));
      end
   end

   assign full_sum = lo_sum + hi_sum;
   assign lo_lane  = lo_sum[DATA_W-1:0];  // Carries out of a lane are dropped.
   assign hi_lane  = hi_sum[DATA_W-1:0];

   assign next_result = dual ? {hi_lane, lo_lane} : full_sum;

   // ====================
   // Result register
   // ====================

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         result <= '0;
      end else begin
         result <= next_result;
      end
   end

   // Operand registers come out of reset at zero.
   a_idle_after_reset : assert property (
      @(posedge clk) $rose(arst_n) |=> (result == '0)
   ) else $error("result not zero after reset release");

endmodule

/* tests/dsp_mul_golden.txt */
# mode a b result, all hex
# mode 0 u16, 1 s16, 2 u8x2, 3 s8x2
# unsigned 16x16
0 0000 0000 00000000
0 0001 0001 00000001
0 0003 0005 0000000f
0 ffff ffff fffe0001
0 8000 0002 00010000
0 8000 8000 40000000
0 1234 5678 06260060
0 ffff 0001 0000ffff
0 0001 ffff 0000ffff
0 abcd ffff abcc5433
0 c000 4000 30000000
0 8001 fffe 7ffffffe
# signed 16x16
1 0003 0005 0000000f
1 ffff ffff 00000001
1 8000 8000 40000000
1 8000 ffff 00008000
1 ffff 8000 00008000
1 7fff 7fff 3fff0001
1 7fff 8000 c0008000
1 fffe 0003 fffffffa
1 1234 ffff ffffedcc
1 8000 0001 ffff8000
1 1234 5678 06260060
1 fff0 0010 ffffff00
# unsigned dual 8x8
2 ffff ffff fe01fe01
2 0203 0405 0008000f
2 80ff 02ff 0100fe01
2 ff01 ff01 fe010001
2 1234 5678 060c1860
2 8080 8080 40004000
2 01ff 01ff 0001fe01
2 c0a5 0203 018001ef
# signed dual 8x8
3 ffff ffff 00010001
3 8080 8080 40004000
3 80ff ff80 00800080
3 05fd 0703 0023fff7
3 7f7f 7f81 3f01c0ff
3 02fe fd02 fffafffc
3 1234 5678 060c1860
3 7f80 807f c080c080
3 0180 01ff 00010080
# mode changes every cycle
0 8001 0003 00018003
1 8001 0003 fffe8003
2 8001 0303 01800003
3 8001 0303 fe800003
0 00ff 00ff 0000fe01
3 00ff 00ff 00000001
1 00ff 00ff 0000fe01
2 ff00 ff00 fe010000
1 ff00 ff00 00010000
0 ff00 ff00 fe010000
3 ff00 ff00 00010000

/* tests/tb_clock.sv */
module tb_clock #(
   parameter int HALF_PERIOD  = 4,
   parameter int RESET_CYCLES = 8
) (
   output logic clk,
   output logic arst_n
);

   initial begin
      clk = 1'b0;
      forever #HALF_PERIOD clk = ~clk;
   end

   // Reset covers the first rising edges.
   initial begin
      arst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      arst_n <= 1'b1;
   end

endmodule

/* tests/tb_dsp_mul.sv */
module tb_dsp_mul
   import dsp_pkg::*;
();

   localparam int    DATA_W       = 16;
   localparam int    RESET_CYCLES = 8;
   localparam string GOLDEN       = "tests/dsp_mul_golden.txt";

   logic                clk;
   logic                arst_n;
   mode_t               mode;
   logic [DATA_W-1:0]   a;
   logic [DATA_W-1:0]   b;
   logic [2*DATA_W-1:0] result;

   logic [1:0]          vec_mode[$];
   logic [DATA_W-1:0]   vec_a[$];
   logic [DATA_W-1:0]   vec_b[$];
   logic [2*DATA_W-1:0] vec_res[$];

   int cycles = 0;
   int cycle_limit;

   tb_clock #(
      .HALF_PERIOD  (4),
      .RESET_CYCLES (RESET_CYCLES)
   ) u_clock (
      .clk    (clk),
      .arst_n (arst_n)
   );

   dsp_mul #(.DATA_W(DATA_W)) dut (
      .clk    (clk),
      .arst_n (arst_n),
      .mode   (mode),
      .a      (a),
      .b      (b),
      .result (result)
   );

   // ====================
   // Helpers
   // ====================

   task automatic abort_run();
      $display("Simulation failed");
      $fatal(1, "run stopped");
   endtask

   task automatic compare_value(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
      if (actual !== expected) begin
         $display("mismatch at %0t: %s expected %08h got %08h",
                  $time, name, expected, actual);
         abort_run();
      end
   endtask

   // One vector per line, lines starting with # are skipped.
   task automatic read_golden();
      int          fd;
      int          count;
      string       line;
      logic [31:0] f_mode;
      logic [31:0] f_a;
      logic [31:0] f_b;
      logic [31:0] f_res;

      fd = $fopen(GOLDEN, "r");
      if (fd == 0) begin
         $display("Cannot open the golden file %s", GOLDEN);
         abort_run();
      end
      while (!$feof(fd)) begin
         line  = "";
         count = $fgets(line, fd);
         if (line.len() > 0 && line.getc(0) != "#") begin
            count = $sscanf(line, "%h %h %h %h", f_mode, f_a, f_b, f_res);
            if (count == 4) begin
               vec_mode.push_back(f_mode[1:0]);
               vec_a.push_back(f_a[DATA_W-1:0]);
               vec_b.push_back(f_b[DATA_W-1:0]);
               vec_res.push_back(f_res);
            end
         end
      end
      $fclose(fd);
      if (vec_a.size() == 0) begin
         $display("The golden file %s holds no vectors", GOLDEN);
         abort_run();
      end
   endtask

   // ====================
   // Timeout
   // ====================

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycle_limit > 0 && cycles > cycle_limit) begin
         $display("Timeout after %0d cycles, the results did not all arrive", cycles);
         abort_run();
      end
   end

   // ====================
   // Stimulus and checks
   // ====================

   initial begin
      mode        = MODE_U16;
      a           = '0;
      b           = '0;
      cycle_limit = 0;

      read_golden();
      cycle_limit = vec_a.size() + RESET_CYCLES + 10;

      wait (arst_n === 1'b1);
      @(negedge clk);
      compare_value("result", '0, result);  // Idle value out of reset.

      // Vector c is driven here and checked two falling edges later.
      for (int c = 0; c < vec_a.size() + 2; c++) begin
         if (c >= 2) begin
            compare_value("result", vec_res[c-2], result);
         end
         if (c < vec_a.size()) begin
            mode = mode_t'(vec_mode[c]);
            a    = vec_a[c];
            b    = vec_b[c];
         end
         @(negedge clk);
      end

      $display("%0d vectors checked", vec_a.size());
      $display("Simulation passed");
      $finish;
   end

endmodule
